// File: source/flitPkg.sv
`default_nettype none

package flitPkg;

  // flit identifier and payload widths.
  localparam int flitIdWidth = 3;
  localparam int dataWidth   = 32;

  // the header payload carries the packet length in its low bits.
  localparam int lengthWidth = 12;

  typedef logic [flitIdWidth-1:0] flitIdT;

  // these identifier encodings match the existing mesh routers.
  localparam flitIdT idHeader = 3'd1;
  localparam flitIdT idBody   = 3'd2;

endpackage : flitPkg

`default_nettype wire

// File: source/portPkg.sv
`default_nettype none

package portPkg;

  localparam int numPorts     = 5;
  localparam int portIdxWidth = 3;

  // port indices follow the default priority order.
  localparam int portL = 0;
  localparam int portN = 1;
  localparam int portE = 2;
  localparam int portW = 3;
  localparam int portS = 4;

  localparam int queueDepth = 4; // flits held per input port.

endpackage : portPkg

`default_nettype wire

// File: source/inputPort.sv
`timescale 1ns/1ps
`default_nettype none

module inputPort (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          inValid,
  output logic                          inReady,
  input  flitPkg::flitIdT               inFlitId,
  input  logic [flitPkg::dataWidth-1:0] inData,
  input  logic                          pop,
  output logic                          headValid,
  output flitPkg::flitIdT               headFlitId,
  output logic [flitPkg::dataWidth-1:0] headData,
  output logic                          headLast
);
  import flitPkg::*;
  import portPkg::*;

  flitIdT                          idMem [queueDepth];
  logic [dataWidth-1:0]            dataMem [queueDepth];
  logic [$clog2(queueDepth)-1:0]   rdPtr;
  logic [$clog2(queueDepth)-1:0]   wrPtr;
  logic [$clog2(queueDepth+1)-1:0] fill;
  logic                            push;
  logic                            doPop;
  logic [lengthWidth-1:0]          headerLen;
  logic [lengthWidth-1:0]          pktLen;
  logic [lengthWidth-1:0]          curLen;
  logic [lengthWidth-1:0]          flitCount;

  assign inReady    = (fill != queueDepth);
  assign headValid  = (fill != 0);
  assign push       = inValid && inReady;
  assign doPop      = pop && headValid;
  assign headFlitId = idMem[rdPtr];
  assign headData   = dataMem[rdPtr];

  always_ff @(posedge clk)
  begin
    if (push)
    begin
      idMem[wrPtr]   <= inFlitId;
      dataMem[wrPtr] <= inData;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rdPtr <= '0;
      wrPtr <= '0;
      fill  <= '0;
    end
    else
    begin
      if (push)
        wrPtr <= (wrPtr == queueDepth - 1) ? '0 : wrPtr + 1'b1;
      if (doPop)
        rdPtr <= (rdPtr == queueDepth - 1) ? '0 : rdPtr + 1'b1;
      if (push && !doPop)
        fill <= fill + 1'b1;
      else if (doPop && !push)
        fill <= fill - 1'b1;
    end
  end

  // a header that says zero still stands for itself.
  assign headerLen = (headData[lengthWidth-1:0] == '0) ? lengthWidth'(1)
                                                       : headData[lengthWidth-1:0];
  assign curLen    = (headFlitId == idHeader) ? headerLen : pktLen;
  assign headLast  = headValid && (flitCount + 1'b1 >= curLen);

  // flitCount counts the flits of the current packet that have already left.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      flitCount <= '0;
      pktLen    <= lengthWidth'(1);
    end
    else
    begin
      if (headValid && headFlitId == idHeader)
        pktLen <= headerLen;
      if (doPop)
        flitCount <= headLast ? '0 : flitCount + 1'b1; // restart for the next header.
    end
  end

endmodule : inputPort

`default_nettype wire

// File: source/switchAllocator.sv
`timescale 1ns/1ps
`default_nettype none

module switchAllocator (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [portPkg::numPorts-1:0] headValid,
  input  logic [portPkg::numPorts-1:0] headLast,
  input  logic [portPkg::numPorts-1:0] pop,
  output logic [portPkg::numPorts-1:0] grant
);
  import portPkg::*;

  logic [portIdxWidth-1:0] lastWinner;
  logic [portIdxWidth-1:0] nextWinner;
  logic [numPorts-1:0]     request;
  logic                    found;
  logic                    pktDone;
  logic                    canGrant;

  // the granted port has just sent the tail of its packet.
  assign pktDone  = |(grant & pop & headLast);
  assign canGrant = (grant == '0) || pktDone;

  // the head of a port being popped now is gone next cycle, so it does not count.
  assign request = headValid & ~pop;

  // search starts after the last winner and wraps, so the winner itself comes last.
  always_comb
  begin
    int idx;
    nextWinner = lastWinner;
    found      = 1'b0;
    for (int i = 1; i <= numPorts; i++)
    begin
      idx = int'(lastWinner) + i;
      if (idx >= numPorts)
        idx = idx - numPorts;
      if (!found && request[idx])
      begin
        found      = 1'b1;
        nextWinner = portIdxWidth'(idx);
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      grant      <= '0;
      lastWinner <= portIdxWidth'(portS); // so that Local is looked at first.
    end
    else if (canGrant)
    begin
      if (found)
      begin
        grant      <= numPorts'(1) << nextWinner;
        lastWinner <= nextWinner;
      end
      else
      begin
        grant <= '0;
      end
    end
  end

endmodule : switchAllocator

`default_nettype wire

// File: source/outputStage.sv
`timescale 1ns/1ps
`default_nettype none

module outputStage (
  input  logic                             clk,
  input  logic                             rst,
  input  logic [portPkg::numPorts-1:0]     grant,
  input  logic [portPkg::numPorts-1:0]     headValid,
  input  flitPkg::flitIdT                  headFlitId [portPkg::numPorts],
  input  logic [flitPkg::dataWidth-1:0]    headData [portPkg::numPorts],
  input  logic                             outReady,
  output logic [portPkg::numPorts-1:0]     pop,
  output logic                             outValid,
  output flitPkg::flitIdT                  outFlitId,
  output logic [flitPkg::dataWidth-1:0]    outData,
  output logic [portPkg::portIdxWidth-1:0] outPort
);
  import flitPkg::*;
  import portPkg::*;

  logic                    outFree;
  flitIdT                  selFlitId;
  logic [dataWidth-1:0]    selData;
  logic [portIdxWidth-1:0] selPort;

  assign outFree = !outValid || outReady; // register empty or draining this cycle.
  assign pop     = grant & headValid & {numPorts{outFree}};

  // grant is one-hot, so at most one term is taken.
  always_comb
  begin
    selFlitId = '0;
    selData   = '0;
    selPort   = '0;
    for (int i = 0; i < numPorts; i++)
    begin
      if (grant[i])
      begin
        selFlitId = headFlitId[i];
        selData   = headData[i];
        selPort   = portIdxWidth'(i);
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else if (outFree)
      outValid <= |pop;
  end

  always_ff @(posedge clk)
  begin
    if (|pop)
    begin
      outFlitId <= selFlitId;
      outData   <= selData;
      outPort   <= selPort;
    end
  end

endmodule : outputStage

`default_nettype wire

// File: source/flitArbiter.sv
`timescale 1ns/1ps
`default_nettype none

module flitArbiter (
  input  logic                             clk,
  input  logic                             rst,
  input  logic [portPkg::numPorts-1:0]     inValid,
  output logic [portPkg::numPorts-1:0]     inReady,
  input  flitPkg::flitIdT                  inFlitId [portPkg::numPorts],
  input  logic [flitPkg::dataWidth-1:0]    inData [portPkg::numPorts],
  output logic                             outValid,
  input  logic                             outReady,
  output flitPkg::flitIdT                  outFlitId,
  output logic [flitPkg::dataWidth-1:0]    outData,
  output logic [portPkg::portIdxWidth-1:0] outPort
);
  import flitPkg::*;
  import portPkg::*;

  logic [numPorts-1:0]  headValid;
  logic [numPorts-1:0]  headLast;
  logic [numPorts-1:0]  pop;
  logic [numPorts-1:0]  grant;
  flitIdT               headFlitId [numPorts];
  logic [dataWidth-1:0] headData [numPorts];

  // one queue per port, indexed as Local, North, East, West, South.
  for (genvar p = 0; p < numPorts; p++)
  begin : gPort
    inputPort i_inputPort (
      .clk        (clk),
      .rst        (rst),
      .inValid    (inValid[p]),
      .inReady    (inReady[p]),
      .inFlitId   (inFlitId[p]),
      .inData     (inData[p]),
      .pop        (pop[p]),
      .headValid  (headValid[p]),
      .headFlitId (headFlitId[p]),
      .headData   (headData[p]),
      .headLast   (headLast[p])
    );
  end

  switchAllocator i_switchAllocator (
    .clk       (clk),
    .rst       (rst),
    .headValid (headValid),
    .headLast  (headLast),
    .pop       (pop),
    .grant     (grant)
  );

  outputStage i_outputStage (
    .clk        (clk),
    .rst        (rst),
    .grant      (grant),
    .headValid  (headValid),
    .headFlitId (headFlitId),
    .headData   (headData),
    .outReady   (outReady),
    .pop        (pop),
    .outValid   (outValid),
    .outFlitId  (outFlitId),
    .outData    (outData),
    .outPort    (outPort)
  );

endmodule : flitArbiter

`default_nettype wire

// File: include/tbChecks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// running totals for the whole simulation.
int errorCount = 0;
int checkCount = 0;

// compares one value and reports a mismatch in hex.
task automatic checkEq(
  input string       name,
  input logic [63:0] actual,
  input logic [63:0] expected
);
  checkCount++;
  if (actual !== expected)
  begin
    errorCount++;
    $display("FAILED %s: actual 0x%0h expected 0x%0h at %0t", name, actual, expected, $time);
  end
endtask

`endif

// File: dv/flitArbiterTb.sv
`timescale 1ns/1ps
`default_nettype none

module flitArbiterTb;
  import flitPkg::*;
  import portPkg::*;

  `include "tbChecks.svh"

  localparam int flitW  = flitIdWidth + dataWidth;
  localparam int entryW = 4 + flitW; // gap cycles ahead of the flit, then id and payload.

  logic                    clk = 1'b0;
  logic                    rst;
  logic [numPorts-1:0]     inValid;
  logic [numPorts-1:0]     inReady;
  flitIdT                  inFlitId [numPorts];
  logic [dataWidth-1:0]    inData [numPorts];
  logic                    outValid;
  logic                    outReady;
  flitIdT                  outFlitId;
  logic [dataWidth-1:0]    outData;
  logic [portIdxWidth-1:0] outPort;

  logic [entryW-1:0]       sendQ [numPorts][$];
  logic [flitW-1:0]        expQ [numPorts][$];
  logic [portIdxWidth-1:0] serviceOrder [$];
  logic [portIdxWidth-1:0] curPort = '0;
  logic [flitW-1:0]        expFlit;
  logic                    backPressure = 1'b0;
  logic                    recordOrder = 1'b0;
  int                      remaining = 0;
  int                      totalFlits = 0;
  int                      cycleCount = 0;

  flitArbiter i_flitArbiter (
    .clk       (clk),
    .rst       (rst),
    .inValid   (inValid),
    .inReady   (inReady),
    .inFlitId  (inFlitId),
    .inData    (inData),
    .outValid  (outValid),
    .outReady  (outReady),
    .outFlitId (outFlitId),
    .outData   (outData),
    .outPort   (outPort)
  );

  always #4 clk = ~clk;

  // length of a packet in flits, as its header states it.
  function automatic int packetLength(input logic [dataWidth-1:0] header);
    int len;
    len = int'(header[lengthWidth-1:0]);
    return (len == 0) ? 1 : len;
  endfunction

  function automatic flitIdT expectedFlitId(input int index);
    return (index == 0) ? idHeader : idBody;
  endfunction

  // first port after the last winner that has a request, wrapping around.
  function automatic int nextInRotation(input int last, input logic [numPorts-1:0] mask);
    int idx;
    for (int i = 1; i <= numPorts; i++)
    begin
      idx = (last + i) % numPorts;
      if (mask[idx])
        return idx;
    end
    return -1;
  endfunction

  task automatic sendPacket(input int port, input int lenField, input int maxGap);
    logic [dataWidth-1:0] payload;
    int                   n;
    payload = $urandom;
    payload[lengthWidth-1:0] = lengthWidth'(lenField);
    n = packetLength(payload);
    for (int i = 0; i < n; i++)
    begin
      if (i > 0)
        payload = $urandom;
      sendQ[port].push_back({4'($urandom_range(maxGap, 0)), expectedFlitId(i), payload});
      expQ[port].push_back({expectedFlitId(i), payload});
    end
    totalFlits += n;
  endtask

  task automatic waitDrain();
    logic busy;
    busy = 1'b1;
    while (busy)
    begin
      @(posedge clk);
      busy = 1'b0;
      for (int p = 0; p < numPorts; p++)
        if (sendQ[p].size() != 0 || expQ[p].size() != 0)
          busy = 1'b1;
    end
    repeat (4) @(posedge clk);
  endtask

  // one driver per port, feeding its flits one handshake at a time.
  for (genvar p = 0; p < numPorts; p++)
  begin : gDriver
    initial
    begin
      logic [entryW-1:0] entry;
      logic              accepted;
      @(posedge clk);
      #1;
      forever
      begin
        if (sendQ[p].size() == 0)
        begin
          inValid[p] = 1'b0;
          @(posedge clk);
          #1;
        end
        else
        begin
          entry = sendQ[p].pop_front();
          inValid[p] = 1'b0;
          repeat (entry[entryW-1 -: 4])
          begin
            @(posedge clk);
            #1;
          end
          inValid[p]  = 1'b1;
          inFlitId[p] = entry[flitW-1 -: flitIdWidth];
          inData[p]   = entry[dataWidth-1:0];
          accepted    = 1'b0;
          while (!accepted)
          begin
            @(negedge clk);
            accepted = inReady[p]; // ready only moves on the clock edge.
            @(posedge clk);
            #1;
          end
        end
      end
    end
  end

  always @(posedge clk)
  begin
    #1;
    if (backPressure)
      outReady = ($urandom % 3) != 0;
    else
      outReady = 1'b1;
  end

  // compares every output transfer with the front of its port's expected queue.
  always @(negedge clk)
  begin
    if (!rst && outValid && outReady)
    begin
      if (remaining != 0)
        checkEq("outPort", outPort, curPort); // a packet must not be interleaved.
      if (expQ[outPort].size() == 0)
      begin
        errorCount++;
        $display("Flit received from port %0d that was never sent, at %0t", outPort, $time);
      end
      else
      begin
        expFlit = expQ[outPort].pop_front();
        checkEq("outFlitId", outFlitId, expFlit[flitW-1 -: flitIdWidth]);
        checkEq("outData", outData, expFlit[dataWidth-1:0]);
        if (expFlit[flitW-1 -: flitIdWidth] == idHeader)
        begin
          remaining = packetLength(expFlit[dataWidth-1:0]);
          curPort   = outPort;
          if (recordOrder)
            serviceOrder.push_back(outPort);
        end
      end
      if (remaining > 0)
        remaining--;
    end
  end

  initial
  begin
    cycleCount = 0;
    while (cycleCount <= 200 * (totalFlits + 1))
    begin
      @(posedge clk);
      cycleCount++;
    end
    $display("The run timed out after %0d cycles with flits still outstanding", cycleCount);
    $display("%0d checks, %0d errors", checkCount, errorCount);
    $display("Some tests failed");
    $finish;
  end

  initial
  begin
    int lastPort;
    int wantPort;
    void'($urandom(58));
    rst      = 1'b1;
    inValid  = '0;
    outReady = 1'b0;
    for (int p = 0; p < numPorts; p++)
    begin
      inFlitId[p] = '0;
      inData[p]   = '0;
    end
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    checkEq("outValid", outValid, 1'b0);
    checkEq("inReady", inReady, {numPorts{1'b1}});

    // two packets per port, all waiting before the first grant.
    recordOrder = 1'b1;
    for (int r = 0; r < 2; r++)
      for (int p = 0; p < numPorts; p++)
        sendPacket(p, $urandom_range(6, 1), 0);
    waitDrain();
    recordOrder = 1'b0;
    checkEq("service order length", serviceOrder.size(), 2 * numPorts);
    lastPort = portS;
    for (int k = 0; k < 2 * numPorts; k++)
    begin
      wantPort = nextInRotation(lastPort, '1);
      if (k < serviceOrder.size())
        checkEq("service order", serviceOrder[k], wantPort);
      lastPort = wantPort;
    end

    sendPacket(portN, 4, 0);
    waitDrain();

    // header-only packets must hand the grant on to the next packet.
    sendPacket(portE, 0, 0);
    sendPacket(portE, 1, 0);
    sendPacket(portL, 3, 0);
    waitDrain();

    for (int n = 0; n < 8; n++)
      for (int p = 0; p < numPorts; p++)
        sendPacket(p, $urandom_range(6, 1), 3);
    waitDrain();

    backPressure = 1'b1;
    for (int n = 0; n < 8; n++)
      for (int p = 0; p < numPorts; p++)
        sendPacket(p, $urandom_range(6, 1), 0);
    waitDrain();
    backPressure = 1'b0;
    repeat (10) @(posedge clk);

    $display("%0d checks, %0d errors", checkCount, errorCount);
    if (errorCount == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule : flitArbiterTb

`default_nettype wire

// File: flitArbiter.f
+incdir+include
source/flitPkg.sv
source/portPkg.sv
source/inputPort.sv
source/switchAllocator.sv
source/outputStage.sv
source/flitArbiter.sv
dv/flitArbiterTb.sv
